//--- design/mesh_cfg.svh
// mesh pod array configuration constants for array size, link widths and reset delay
`ifndef MESH_CFG_SVH
`define MESH_CFG_SVH

// pods stacked vertically and pods across
`define MESH_NUM_PODS_Y 2
`define MESH_NUM_PODS_X 2

// tile grid inside one pod
`define MESH_TILES_Y 2
`define MESH_TILES_X 2

// scratch memory word address and data width
`define MESH_ADDR_W 2
`define MESH_DATA_W 16

// global row and request tag widths
`define MESH_ROW_W 3
`define MESH_TAG_W 4

// stages between the POD_RESET register and the pod
`define MESH_RESET_DEPTH 3

`endif

//--- design/mesh_pkg.sv
// mesh link payload types: opcode, southbound request and northbound response
`include "mesh_cfg.svh"

package mesh_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  // travels south until its destination row is reached
  typedef struct packed {
    op_e                    op;
    logic [`MESH_ROW_W-1:0]  row;
    logic [`MESH_ADDR_W-1:0] addr;
    logic [`MESH_TAG_W-1:0]  tag;
    logic [`MESH_DATA_W-1:0] data;
  } req_s;

  // travels north to the edge of the column
  typedef struct packed {
    logic [`MESH_TAG_W-1:0]  tag;
    logic [`MESH_ROW_W-1:0]  src_row;
    logic [`MESH_DATA_W-1:0] data;
  } resp_s;

endpackage

//--- design/link_fifo.sv
// two-entry valid/ready link buffer with registered handshake on both sides
module link_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i
);

  payload_t   slot_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic [1:0] count_n;
  logic       in_ready_q;
  logic       out_valid_q;
  logic       push;
  logic       pop;

  assign in_ready_o  = in_ready_q;
  assign out_valid_o = out_valid_q;
  assign out_data_o  = slot_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_q;
  assign pop  = out_valid_q & out_ready_i;

  always_comb begin
    count_n = count_q;
    if (push && !pop) begin
      count_n = count_q + 2'd1;
    end else if (pop && !push) begin
      count_n = count_q - 2'd1;
    end
  end

  // flags come from the next count so both sides see a flop output
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q    <= 1'b0;
      rd_ptr_q    <= 1'b0;
      count_q     <= 2'd0;
      in_ready_q  <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q     <= count_n;
      in_ready_q  <= (count_n != 2'd2);
      out_valid_q <= (count_n != 2'd0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      slot_q[wr_ptr_q] <= in_data_i;
    end
  end

endmodule

//--- design/mesh_tile.sv
// mesh tile: decodes the destination row, executes on its scratch memory, merges responses
`include "mesh_cfg.svh"

module mesh_tile (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic [`MESH_ROW_W-1:0] my_row_i,
  // request from north
  input  logic                   req_valid_i,
  input  mesh_pkg::req_s         req_data_i,
  output logic                   req_ready_o,
  // request to south
  output logic                   sreq_valid_o,
  output mesh_pkg::req_s         sreq_data_o,
  input  logic                   sreq_ready_i,
  // response from south
  input  logic                   sresp_valid_i,
  input  mesh_pkg::resp_s        sresp_data_i,
  output logic                   sresp_ready_o,
  // response to north
  output logic                   resp_valid_o,
  output mesh_pkg::resp_s        resp_data_o,
  input  logic                   resp_ready_i
);

  localparam int NUM_WORDS = 2 ** `MESH_ADDR_W;

  logic [`MESH_DATA_W-1:0] mem_q [NUM_WORDS];

  logic            rq_valid;
  mesh_pkg::req_s  rq_data;
  logic            rq_ready;

  logic            dec_match;
  logic            dec_write;
  logic            dec_read;

  logic            own_in_valid;
  mesh_pkg::resp_s own_in_data;
  logic            own_in_ready;
  logic            own_valid;
  mesh_pkg::resp_s own_data;
  logic            own_ready;

  logic            nb_in_valid;
  mesh_pkg::resp_s nb_in_data;
  logic            nb_in_ready;

  // one buffered hop on the request path
  link_fifo #(
    .payload_t(mesh_pkg::req_s)
  ) req_fifo (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .in_valid_i (req_valid_i),
    .in_data_i  (req_data_i),
    .in_ready_o (req_ready_o),
    .out_valid_o(rq_valid),
    .out_data_o (rq_data),
    .out_ready_i(rq_ready)
  );

  // decode
  assign dec_match = (rq_data.row == my_row_i);
  assign dec_write = rq_valid & dec_match & (rq_data.op == mesh_pkg::OP_WRITE);
  assign dec_read  = rq_valid & dec_match & (rq_data.op == mesh_pkg::OP_READ);

  // other rows go on south, writes retire at once, reads need room for a response
  assign sreq_valid_o = rq_valid & ~dec_match;
  assign sreq_data_o  = rq_data;
  assign rq_ready     = dec_match ? (rq_data.op == mesh_pkg::OP_WRITE) | own_in_ready
                                  : sreq_ready_i;

  // execute
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (dec_write) begin
      mem_q[rq_data.addr] <= rq_data.data;
    end
  end

  assign own_in_valid        = dec_read;
  assign own_in_data.tag     = rq_data.tag;
  assign own_in_data.src_row = my_row_i;
  assign own_in_data.data    = mem_q[rq_data.addr];

  link_fifo #(
    .payload_t(mesh_pkg::resp_s)
  ) own_fifo (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .in_valid_i (own_in_valid),
    .in_data_i  (own_in_data),
    .in_ready_o (own_in_ready),
    .out_valid_o(own_valid),
    .out_data_o (own_data),
    .out_ready_i(own_ready)
  );

  // result: traffic from below wins, the own response holds in its buffer
  assign nb_in_valid   = sresp_valid_i | own_valid;
  assign nb_in_data    = sresp_valid_i ? sresp_data_i : own_data;
  assign sresp_ready_o = nb_in_ready;
  assign own_ready     = nb_in_ready & ~sresp_valid_i;

  link_fifo #(
    .payload_t(mesh_pkg::resp_s)
  ) nb_fifo (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .in_valid_i (nb_in_valid),
    .in_data_i  (nb_in_data),
    .in_ready_o (nb_in_ready),
    .out_valid_o(resp_valid_o),
    .out_data_o (resp_data_o),
    .out_ready_i(resp_ready_i)
  );

endmodule

//--- design/mesh_pod.sv
// mesh pod: grid of tiles chained south for requests and north for responses
`include "mesh_cfg.svh"

module mesh_pod (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  logic [`MESH_ROW_W-1:0]                  base_row_i,
  // north edge
  input  logic [`MESH_TILES_X-1:0]                req_valid_i,
  input  mesh_pkg::req_s [`MESH_TILES_X-1:0]      req_data_i,
  output logic [`MESH_TILES_X-1:0]                req_ready_o,
  output logic [`MESH_TILES_X-1:0]                resp_valid_o,
  output mesh_pkg::resp_s [`MESH_TILES_X-1:0]     resp_data_o,
  input  logic [`MESH_TILES_X-1:0]                resp_ready_i,
  // south edge
  output logic [`MESH_TILES_X-1:0]                sreq_valid_o,
  output mesh_pkg::req_s [`MESH_TILES_X-1:0]      sreq_data_o,
  input  logic [`MESH_TILES_X-1:0]                sreq_ready_i,
  input  logic [`MESH_TILES_X-1:0]                sresp_valid_i,
  input  mesh_pkg::resp_s [`MESH_TILES_X-1:0]     sresp_data_i,
  output logic [`MESH_TILES_X-1:0]                sresp_ready_o
);

  // index r is the link on the north side of tile row r
  logic            [`MESH_TILES_Y:0][`MESH_TILES_X-1:0] rq_v;
  mesh_pkg::req_s  [`MESH_TILES_Y:0][`MESH_TILES_X-1:0] rq_d;
  logic            [`MESH_TILES_Y:0][`MESH_TILES_X-1:0] rq_r;
  logic            [`MESH_TILES_Y:0][`MESH_TILES_X-1:0] rs_v;
  mesh_pkg::resp_s [`MESH_TILES_Y:0][`MESH_TILES_X-1:0] rs_d;
  logic            [`MESH_TILES_Y:0][`MESH_TILES_X-1:0] rs_r;

  assign rq_v[0]       = req_valid_i;
  assign rq_d[0]       = req_data_i;
  assign req_ready_o   = rq_r[0];
  assign resp_valid_o  = rs_v[0];
  assign resp_data_o   = rs_d[0];
  assign rs_r[0]       = resp_ready_i;

  assign sreq_valid_o           = rq_v[`MESH_TILES_Y];
  assign sreq_data_o            = rq_d[`MESH_TILES_Y];
  assign rq_r[`MESH_TILES_Y]    = sreq_ready_i;
  assign rs_v[`MESH_TILES_Y]    = sresp_valid_i;
  assign rs_d[`MESH_TILES_Y]    = sresp_data_i;
  assign sresp_ready_o          = rs_r[`MESH_TILES_Y];

  for (genvar r = 0; r < `MESH_TILES_Y; r++) begin : g_row
    logic [`MESH_ROW_W-1:0] row_id;

    assign row_id = base_row_i + (`MESH_ROW_W)'(r);

    for (genvar c = 0; c < `MESH_TILES_X; c++) begin : g_col
      mesh_tile tile (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .my_row_i     (row_id),
        .req_valid_i  (rq_v[r][c]),
        .req_data_i   (rq_d[r][c]),
        .req_ready_o  (rq_r[r][c]),
        .sreq_valid_o (rq_v[r+1][c]),
        .sreq_data_o  (rq_d[r+1][c]),
        .sreq_ready_i (rq_r[r+1][c]),
        .sresp_valid_i(rs_v[r+1][c]),
        .sresp_data_i (rs_d[r+1][c]),
        .sresp_ready_o(rs_r[r+1][c]),
        .resp_valid_o (rs_v[r][c]),
        .resp_data_o  (rs_d[r][c]),
        .resp_ready_i (rs_r[r][c])
      );
    end
  end

endmodule

//--- design/pod_reset_ctrl.sv
// pod reset controller: APB POD_RESET register feeding a per-pod reset delay chain
`include "mesh_cfg.svh"

module pod_reset_ctrl (
  input  logic        clk_i,
  input  logic        rst_i,
  // APB slave
  input  logic [7:0]  paddr_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  // one reset per pod, row-major
  output logic [`MESH_NUM_PODS_Y*`MESH_NUM_PODS_X-1:0] pod_rst_o
);

  localparam int NUM_PODS = `MESH_NUM_PODS_Y * `MESH_NUM_PODS_X;
  localparam logic [7:0] POD_RESET_OFS = 8'h00;

  logic [NUM_PODS-1:0]                         pod_reset_q;
  logic [`MESH_RESET_DEPTH-1:0][NUM_PODS-1:0]  stage_q;
  logic                                        access;
  logic                                        hit;

  assign access = psel_i & penable_i;
  assign hit    = (paddr_i == POD_RESET_OFS);

  // no wait states
  assign pready_o  = 1'b1;
  assign pslverr_o = access & ~hit;
  assign prdata_o  = hit ? 32'(pod_reset_q) : 32'h0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pod_reset_q <= '1;
    end else if (access && pwrite_i && hit) begin
      pod_reset_q <= pwdata_i[NUM_PODS-1:0];
    end
  end

  // a new value reaches the pods MESH_RESET_DEPTH cycles after the write
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      stage_q <= '1;
    end else begin
      stage_q[0] <= pod_reset_q;
      for (int i = 1; i < `MESH_RESET_DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign pod_rst_o = stage_q[`MESH_RESET_DEPTH-1];

endmodule

//--- design/mesh_pod_array.sv
// mesh pod array top: per-pod resets, global row assignment and vertical pod stitching
`include "mesh_cfg.svh"

module mesh_pod_array (
  input  logic        clk_i,
  input  logic        rst_i,
  // APB slave for POD_RESET
  input  logic [7:0]  paddr_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  // north edge, one lane per global column
  input  logic [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]            req_valid_i,
  input  mesh_pkg::req_s [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]  req_data_i,
  output logic [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]            req_ready_o,
  output logic [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]            resp_valid_o,
  output mesh_pkg::resp_s [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0] resp_data_o,
  input  logic [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]            resp_ready_i,
  // south edge, requests past the last row
  output logic [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]            sreq_valid_o,
  output mesh_pkg::req_s [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]  sreq_data_o,
  input  logic [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]            sreq_ready_i
);

  localparam int NUM_COLS = `MESH_NUM_PODS_X * `MESH_TILES_X;
  localparam int PODS_Y   = `MESH_NUM_PODS_Y;
  localparam int TX       = `MESH_TILES_X;

  logic [`MESH_NUM_PODS_Y*`MESH_NUM_PODS_X-1:0] pod_rst;

  // index y is the boundary on the north side of pod row y
  logic            [PODS_Y:0][NUM_COLS-1:0] rq_v;
  mesh_pkg::req_s  [PODS_Y:0][NUM_COLS-1:0] rq_d;
  logic            [PODS_Y:0][NUM_COLS-1:0] rq_r;
  logic            [PODS_Y:0][NUM_COLS-1:0] rs_v;
  mesh_pkg::resp_s [PODS_Y:0][NUM_COLS-1:0] rs_d;
  logic            [PODS_Y:0][NUM_COLS-1:0] rs_r;

  pod_reset_ctrl rst_ctrl (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .paddr_i  (paddr_i),
    .psel_i   (psel_i),
    .penable_i(penable_i),
    .pwrite_i (pwrite_i),
    .pwdata_i (pwdata_i),
    .prdata_o (prdata_o),
    .pready_o (pready_o),
    .pslverr_o(pslverr_o),
    .pod_rst_o(pod_rst)
  );

  assign rq_v[0]      = req_valid_i;
  assign rq_d[0]      = req_data_i;
  assign req_ready_o  = rq_r[0];
  assign resp_valid_o = rs_v[0];
  assign resp_data_o  = rs_d[0];
  assign rs_r[0]      = resp_ready_i;

  assign sreq_valid_o = rq_v[PODS_Y];
  assign sreq_data_o  = rq_d[PODS_Y];
  assign rq_r[PODS_Y] = sreq_ready_i;

  // nothing drives responses up from below the bottom pods
  assign rs_v[PODS_Y] = '0;
  assign rs_d[PODS_Y] = '0;

  for (genvar y = 0; y < PODS_Y; y++) begin : g_py
    for (genvar x = 0; x < `MESH_NUM_PODS_X; x++) begin : g_px
      mesh_pod pod (
        .clk_i        (clk_i),
        .rst_i        (pod_rst[y*`MESH_NUM_PODS_X + x]),
        .base_row_i   ((`MESH_ROW_W)'(y * `MESH_TILES_Y)),
        .req_valid_i  (rq_v[y][x*TX +: TX]),
        .req_data_i   (rq_d[y][x*TX +: TX]),
        .req_ready_o  (rq_r[y][x*TX +: TX]),
        .resp_valid_o (rs_v[y][x*TX +: TX]),
        .resp_data_o  (rs_d[y][x*TX +: TX]),
        .resp_ready_i (rs_r[y][x*TX +: TX]),
        .sreq_valid_o (rq_v[y+1][x*TX +: TX]),
        .sreq_data_o  (rq_d[y+1][x*TX +: TX]),
        .sreq_ready_i (rq_r[y+1][x*TX +: TX]),
        .sresp_valid_i(rs_v[y+1][x*TX +: TX]),
        .sresp_data_i (rs_d[y+1][x*TX +: TX]),
        .sresp_ready_o(rs_r[y+1][x*TX +: TX])
      );
    end
  end

endmodule

//--- testbench/mesh_link_checker.sv
// mesh link checker: handshake, reset and APB assertions on the pod array edge ports
`include "mesh_cfg.svh"

module mesh_link_checker (
  input logic                                                  clk_i,
  input logic                                                  rst_i,
  input logic                                                  pready_o,
  input logic [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]             req_valid_i,
  input mesh_pkg::req_s [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]   req_data_i,
  input logic [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]             req_ready_o,
  input logic [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]             resp_valid_o,
  input mesh_pkg::resp_s [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]  resp_data_o,
  input logic [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]             resp_ready_i,
  input logic [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]             sreq_valid_o,
  input mesh_pkg::req_s [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]   sreq_data_o,
  input logic [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]             sreq_ready_i
);

  localparam int NC = `MESH_NUM_PODS_X * `MESH_TILES_X;

  for (genvar c = 0; c < NC; c++) begin : g_lane
    // a stalled transfer keeps its valid and its data
    a_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      req_valid_i[c] && !req_ready_o[c] |=> req_valid_i[c] && $stable(req_data_i[c]))
      else $error("request on lane %0d changed while stalled", c);
    a_resp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      resp_valid_o[c] && !resp_ready_i[c] |=> resp_valid_o[c] && $stable(resp_data_o[c]))
      else $error("response on lane %0d changed while stalled", c);
    a_sreq_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      sreq_valid_o[c] && !sreq_ready_i[c] |=> sreq_valid_o[c] && $stable(sreq_data_o[c]))
      else $error("south request on lane %0d changed while stalled", c);
  end

  // pod resets trail rst_i by the delay stage and then the link buffer registers
  a_reset_quiet: assert property (@(posedge clk_i)
    rst_i && $past(rst_i) && $past(rst_i, 2)
      |-> !(|resp_valid_o) && !(|sreq_valid_o) && !(|req_ready_o))
    else $error("edge handshake active during reset");

  a_pready: assert property (@(posedge clk_i) pready_o)
    else $error("pready_o dropped");

endmodule

bind mesh_pod_array mesh_link_checker chk0 (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .pready_o    (pready_o),
  .req_valid_i (req_valid_i),
  .req_data_i  (req_data_i),
  .req_ready_o (req_ready_o),
  .resp_valid_o(resp_valid_o),
  .resp_data_o (resp_data_o),
  .resp_ready_i(resp_ready_i),
  .sreq_valid_o(sreq_valid_o),
  .sreq_data_o (sreq_data_o),
  .sreq_ready_i(sreq_ready_i)
);

//--- testbench/mesh_scoreboard.sv
// mesh scoreboard: reference memory per tile, response match by tag, south port and APB checks
`include "mesh_cfg.svh"

module mesh_scoreboard (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  input  logic [7:0]                                           paddr_i,
  input  logic                                                 psel_i,
  input  logic                                                 penable_i,
  input  logic                                                 pwrite_i,
  input  logic [31:0]                                          pwdata_i,
  input  logic [31:0]                                          prdata_i,
  input  logic                                                 pslverr_i,
  input  logic [31:0]                                          exp_rdata_i,
  input  logic                                                 exp_err_i,
  input  logic [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]            req_valid_i,
  input  mesh_pkg::req_s [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]  req_data_i,
  input  logic [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]            req_ready_i,
  input  logic [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]            resp_valid_i,
  input  mesh_pkg::resp_s [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0] resp_data_i,
  input  logic [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]            resp_ready_i,
  input  logic [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]            sreq_valid_i,
  input  mesh_pkg::req_s [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]  sreq_data_i,
  input  logic [`MESH_NUM_PODS_X*`MESH_TILES_X-1:0]            sreq_ready_i,
  output int                                                   pending_o,
  output int                                                   errors_o
);

  localparam int TX = `MESH_TILES_X;
  localparam int TY = `MESH_TILES_Y;
  localparam int PX = `MESH_NUM_PODS_X;
  localparam int NP = `MESH_NUM_PODS_Y * PX;
  localparam int NC = PX * TX;
  localparam int NR = `MESH_NUM_PODS_Y * TY;
  localparam int NW = 2 ** `MESH_ADDR_W;
  localparam int NT = 2 ** `MESH_TAG_W;

  logic [`MESH_DATA_W-1:0] ref_mem [NC][NR][NW];
  logic                    exp_v [NC][NT];
  logic [`MESH_ROW_W-1:0]  exp_row [NC][NT];
  logic [`MESH_DATA_W-1:0] exp_data [NC][NT];
  mesh_pkg::req_s          south_q [NC][$];
  // pods that have left the power-on reset
  logic [NP-1:0]           cleared;
  int                      outstanding = 0;
  int                      queued = 0;
  int                      errors = 0;

  assign pending_o = outstanding + queued;
  assign errors_o  = errors;

  task automatic report_mismatch(input string name, input int idx,
                                 input logic [63:0] got, input logic [63:0] exp);
    $display("[FAIL] %s[%0d] got %0h expected %0h", name, idx, got, exp);
    errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic clear_pod(input int p);
    for (int r = (p / PX) * TY; r < (p / PX + 1) * TY; r++) begin
      for (int c = (p % PX) * TX; c < (p % PX + 1) * TX; c++) begin
        for (int w = 0; w < NW; w++) begin
          ref_mem[c][r][w] = '0;
        end
      end
    end
  endtask

  always @(negedge clk_i) begin
    mesh_pkg::req_s  rq;
    mesh_pkg::resp_s rs;
    mesh_pkg::req_s  exp_rq;
    if (rst_i) begin
      for (int p = 0; p < NP; p++) begin
        clear_pod(p);
      end
      for (int c = 0; c < NC; c++) begin
        south_q[c].delete();
        for (int t = 0; t < NT; t++) begin
          exp_v[c][t] = 1'b0;
        end
      end
      cleared     = '0;
      outstanding = 0;
      queued      = 0;
    end else begin
      // APB access phase
      if (psel_i && penable_i) begin
        if (pslverr_i != exp_err_i) begin
          report_mismatch("pslverr_o", 0, 64'(pslverr_i), 64'(exp_err_i));
        end
        if (!pwrite_i && !exp_err_i && prdata_i != exp_rdata_i) begin
          report_mismatch("prdata_o", 0, 64'(prdata_i), 64'(exp_rdata_i));
        end
        if (pwrite_i && paddr_i == 8'h00) begin
          for (int p = 0; p < NP; p++) begin
            if (pwdata_i[p]) begin
              clear_pod(p);
            end else begin
              cleared[p] = 1'b1;
            end
          end
        end
      end
      for (int c = 0; c < NC; c++) begin
        if (req_ready_i[c] && !cleared[c / TX]) begin
          report_problem($sformatf("column %0d accepts requests before its pod left reset", c));
        end
        if (req_valid_i[c] && req_ready_i[c]) begin
          rq = req_data_i[c];
          if (int'(rq.row) >= NR) begin
            south_q[c].push_back(rq);
            queued++;
          end else if (rq.op == mesh_pkg::OP_WRITE) begin
            ref_mem[c][rq.row][rq.addr] = rq.data;
          end else if (exp_v[c][rq.tag]) begin
            report_problem($sformatf("tag %0h reused on column %0d while outstanding", rq.tag, c));
          end else begin
            exp_v[c][rq.tag]    = 1'b1;
            exp_row[c][rq.tag]  = rq.row;
            exp_data[c][rq.tag] = ref_mem[c][rq.row][rq.addr];
            outstanding++;
          end
        end
        if (resp_valid_i[c] && resp_ready_i[c]) begin
          rs = resp_data_i[c];
          if (!exp_v[c][rs.tag]) begin
            report_problem($sformatf("unexpected response on column %0d, tag %0h", c, rs.tag));
          end else begin
            if (rs.src_row != exp_row[c][rs.tag]) begin
              report_mismatch("resp_data_o.src_row", c, 64'(rs.src_row),
                              64'(exp_row[c][rs.tag]));
            end
            if (rs.data != exp_data[c][rs.tag]) begin
              report_mismatch("resp_data_o.data", c, 64'(rs.data), 64'(exp_data[c][rs.tag]));
            end
            exp_v[c][rs.tag] = 1'b0;
            outstanding--;
          end
        end
        if (sreq_valid_i[c] && sreq_ready_i[c]) begin
          if (south_q[c].size() == 0) begin
            report_problem($sformatf("unexpected request at the south port of column %0d", c));
          end else begin
            exp_rq = south_q[c].pop_front();
            queued--;
            if (sreq_data_i[c] != exp_rq) begin
              report_mismatch("sreq_data_o", c, 64'(sreq_data_i[c]), 64'(exp_rq));
            end
          end
        end
      end
    end
  end

endmodule

//--- testbench/mesh_pod_array_tb.sv
// mesh pod array testbench: vector-driven APB and link stimulus with a scoreboard
`include "mesh_cfg.svh"

module mesh_pod_array_tb;

  localparam int NC      = `MESH_NUM_PODS_X * `MESH_TILES_X;
  localparam int NR      = `MESH_NUM_PODS_Y * `MESH_TILES_Y;
  localparam int TIMEOUT = 400;

  logic                     clk_i;
  logic                     rst_i;
  logic [7:0]               paddr_i;
  logic                     psel_i;
  logic                     penable_i;
  logic                     pwrite_i;
  logic [31:0]              pwdata_i;
  logic [31:0]              prdata_o;
  logic                     pready_o;
  logic                     pslverr_o;
  logic [NC-1:0]            req_valid_i;
  mesh_pkg::req_s [NC-1:0]  req_data_i;
  logic [NC-1:0]            req_ready_o;
  logic [NC-1:0]            resp_valid_o;
  mesh_pkg::resp_s [NC-1:0] resp_data_o;
  logic [NC-1:0]            resp_ready_i = '1;
  logic [NC-1:0]            sreq_valid_o;
  mesh_pkg::req_s [NC-1:0]  sreq_data_o;
  logic [NC-1:0]            sreq_ready_i = '1;

  logic [31:0]              exp_rdata;
  logic                     exp_err;
  int                       pending;
  int                       errors;
  logic [31:0]              rnd;
  int                       cycle = 0;
  int                       hold_until = 0;
  logic [`MESH_TAG_W-1:0]   tag_q [NC];
  int                       timeouts;
  int                       tests;

  mesh_pod_array dut0 (
    .clk_i(clk_i), .rst_i(rst_i), .paddr_i(paddr_i), .psel_i(psel_i),
    .penable_i(penable_i), .pwrite_i(pwrite_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
    .pready_o(pready_o), .pslverr_o(pslverr_o), .req_valid_i(req_valid_i),
    .req_data_i(req_data_i), .req_ready_o(req_ready_o), .resp_valid_o(resp_valid_o),
    .resp_data_o(resp_data_o), .resp_ready_i(resp_ready_i), .sreq_valid_o(sreq_valid_o),
    .sreq_data_o(sreq_data_o), .sreq_ready_i(sreq_ready_i)
  );

  mesh_scoreboard sb (
    .clk_i(clk_i), .rst_i(rst_i), .paddr_i(paddr_i), .psel_i(psel_i),
    .penable_i(penable_i), .pwrite_i(pwrite_i), .pwdata_i(pwdata_i), .prdata_i(prdata_o),
    .pslverr_i(pslverr_o), .exp_rdata_i(exp_rdata), .exp_err_i(exp_err),
    .req_valid_i(req_valid_i), .req_data_i(req_data_i), .req_ready_i(req_ready_o),
    .resp_valid_i(resp_valid_o), .resp_data_i(resp_data_o), .resp_ready_i(resp_ready_i),
    .sreq_valid_i(sreq_valid_o), .sreq_data_i(sreq_data_o), .sreq_ready_i(sreq_ready_i),
    .pending_o(pending), .errors_o(errors)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // north response ready drops while a back-pressure stretch runs
  // south request ready alternates so pass-through traffic stalls too
  always @(posedge clk_i) begin
    cycle        <= cycle + 1;
    resp_ready_i <= {NC{cycle >= hold_until}};
    sreq_ready_i <= {NC{cycle[0]}};
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic apb_access(input logic wr, input logic [7:0] addr,
                            input logic [31:0] val, input logic err);
    int n;
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= addr;
    pwdata_i  <= wr ? val : 32'h0;
    exp_rdata <= val;
    exp_err   <= err;
    @(posedge clk_i);
    penable_i <= 1'b1;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!pready_o && n < TIMEOUT);
    if (!pready_o) begin
      $display("timeout: APB access at offset %0h never completed", addr);
      timeouts++;
    end
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic send_request(input int col, input mesh_pkg::op_e op,
                              input int row, input int addr);
    mesh_pkg::req_s rq;
    int             n;
    rnd        = xorshift(rnd);
    rq.op      = op;
    rq.row     = (`MESH_ROW_W)'(row);
    rq.addr    = (`MESH_ADDR_W)'(addr);
    rq.tag     = tag_q[col];
    rq.data    = rnd[`MESH_DATA_W-1:0];
    tag_q[col] = tag_q[col] + 1'b1;
    @(posedge clk_i);
    req_valid_i[col] <= 1'b1;
    req_data_i[col]  <= rq;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!req_ready_o[col] && n < TIMEOUT);
    if (!req_ready_o[col]) begin
      $display("timeout: column %0d never accepted a request", col);
      timeouts++;
    end
    @(posedge clk_i);
    req_valid_i[col] <= 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (pending != 0 && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (pending != 0) begin
      $display("timeout: %0d transfers still outstanding", pending);
      timeouts++;
    end
    // the reset delay chain plus the link buffer's registered ready
    repeat (`MESH_RESET_DEPTH + 2) @(negedge clk_i);
  endtask

  initial begin
    int    fd;
    int    n;
    int    a;
    int    b;
    int    c;
    int    d;
    string line;
    string cmd;
    rst_i        = 1'b1;
    paddr_i      = '0;
    psel_i       = 1'b0;
    penable_i    = 1'b0;
    pwrite_i     = 1'b0;
    pwdata_i     = '0;
    req_valid_i  = '0;
    req_data_i   = '0;
    exp_rdata    = '0;
    exp_err      = 1'b0;
    rnd          = 32'h002feba1;
    tests        = 0;
    timeouts     = 0;
    for (int i = 0; i < NC; i++) begin
      tag_q[i] = '0;
    end
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    fd = $fopen("testbench/mesh_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file");
      timeouts++;
    end
    while (fd != 0 && !$feof(fd) && timeouts == 0) begin
      n = $fgets(line, fd);
      if (n > 1 && line.substr(0, 0) != "#") begin
        n = $sscanf(line, "%s %h %h %h %h", cmd, a, b, c, d);
        case (cmd)
          "W": apb_access(1'b1, a[7:0], b, c[0]);
          "R": apb_access(1'b0, a[7:0], b, c[0]);
          "Q": send_request(a, mesh_pkg::op_e'(b[0]), c, d);
          "P": send_request(a, mesh_pkg::OP_WRITE, b, c);
          "X": begin
            for (int col = 0; col < NC; col++) begin
              for (int row = 0; row < NR; row++) begin
                send_request(col, mesh_pkg::op_e'(a[0]), row, b);
              end
            end
          end
          "B": begin
            rnd = xorshift(rnd);
            @(posedge clk_i);
            hold_until <= cycle + 10 + int'(rnd % 48);
          end
          "I": wait_idle();
          "T": begin
            tests++;
            $display("test %0d finished, %0d errors so far", a, errors);
          end
          default: begin
            $display("unknown vector command %s", cmd);
            timeouts++;
          end
        endcase
      end
    end
    $display("tests: %0d  errors: %0d  timeouts: %0d", tests, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- testbench/mesh_vectors.txt
# cmd a b c d in hex: W addr data err | R addr expected err | Q col op row addr
# X op addr (every row of every column) | P col row addr | B stall | I idle | T test
R 0 f 0 0
T 1 0 0 0
W 0 0 0 0
I 0 0 0 0
X 1 1 0 0
X 0 1 0 0
I 0 0 0 0
T 2 0 0 0
P 0 4 2 0
P 3 7 1 0
I 0 0 0 0
T 3 0 0 0
X 1 2 0 0
B 0 0 0 0
X 0 2 0 0
I 0 0 0 0
T 4 0 0 0
W 0 2 0 0
W 0 0 0 0
I 0 0 0 0
X 0 1 0 0
X 0 2 0 0
I 0 0 0 0
T 5 0 0 0
W 8 5 1 0
R 4 0 1 0
R 0 0 0 0
T 6 0 0 0

//--- mesh_pod_array.f
+incdir+design
design/mesh_pkg.sv
design/link_fifo.sv
design/mesh_tile.sv
design/mesh_pod.sv
design/pod_reset_ctrl.sv
design/mesh_pod_array.sv
testbench/mesh_link_checker.sv
testbench/mesh_scoreboard.sv
testbench/mesh_pod_array_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the mesh pod array testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mesh_pod_array.f \
  --top-module mesh_pod_array_tb -o mesh_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/mesh_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^ALL TESTS PASSED$" sim.log; then
  exit 0
fi
exit 1
